/* logic/loader_params.svh */
// ========================================
// Sizes and fixed addresses of the memory loader
// Included by the packages and RTL that need them
// ========================================
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// Memory address width in bits
`define LDR_ADDR_W 24

// First memory address of the tape image
`define LDR_TAP_BASE 'h200000

// Cycles from a read on the memory port to its data
`define LDR_RD_LAT 2

// Zero-page addresses walked by the BASIC pointer patch
`define LDR_ZP_SIZE 256

`endif

/* logic/mem_pkg.sv */
// ========================================
// Memory port types shared by the slot arbiter and its clients
// ========================================
`include "loader_params.svh"

package mem_pkg;

	// One request on the shared memory port
	typedef struct packed {
		logic                   ce;
		logic                   we;
		logic [`LDR_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_req_t;

	// Client that owns the current memory slot
	typedef enum logic [1:0] {
		OWN_NONE   = 2'd0,
		OWN_LOADER = 2'd1,
		OWN_TAPE   = 2'd2
	} slot_owner_e;

endpackage

/* logic/load_pkg.sv */
// ========================================
// Download stream types and loader states
// ========================================
`include "loader_params.svh"

package load_pkg;

	// One beat of the host download
	typedef struct packed {
		logic                   wr;
		logic [`LDR_ADDR_W-1:0] offset;
		logic [7:0]             data;
	} dl_beat_t;

	// Download index, anything else is ignored
	typedef enum logic [7:0] {
		KIND_PRG = 8'd4,
		KIND_TAP = 8'd6
	} file_kind_e;

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_LOAD,
		LS_PATCH,
		LS_DONE
	} loader_state_e;

	// Tape length handed to the fetcher at the end of a TAP download
	typedef struct packed {
		logic                   load;
		logic [`LDR_ADDR_W-1:0] last;
	} tape_load_t;

endpackage

/* logic/image_loader.sv */
// ========================================
// Writes PRG and TAP downloads to memory, then patches the BASIC
// pointers after a PRG and raises autostart
// ========================================
`timescale 1ns/1ps
`include "loader_params.svh"

module image_loader (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 dl_active_i,
	input  load_pkg::file_kind_e dl_kind_i,
	input  load_pkg::dl_beat_t   dl_beat_i,
	output logic                 dl_wait_o,
	output mem_pkg::mem_req_t    wr_req_o,
	input  logic                 wr_grant_i,
	output load_pkg::tape_load_t tape_load_o,
	output logic                 autostart_o
);
	localparam int ADDR_W = `LDR_ADDR_W;
	localparam int ZP_W = $clog2(`LDR_ZP_SIZE) + 1;
	localparam logic [ADDR_W-1:0] TAP_BASE = `LDR_TAP_BASE;
	localparam logic [ZP_W-1:0] ZP_END = ZP_W'(`LDR_ZP_SIZE);

	load_pkg::loader_state_e state;
	load_pkg::file_kind_e    kind_q;
	logic [15:0]             prg_addr;
	logic [15:0]             end_addr;
	logic [ADDR_W-1:0]       last_off;
	logic [ZP_W-1:0]         zp_addr;
	logic [8:0]              zp_patch;
	logic                    beat_ok;

	// Bit 8 flags a pointer byte, bits 7:0 hold its value after a LOAD
	function automatic logic [8:0] patch_byte(input logic [7:0] addr, input logic [15:0] end_a);
		logic [8:0] res;
		case (addr)
			// Program text start, as after reset
			8'h2B: res = {1'b1, 8'h01};
			8'h2C: res = {1'b1, 8'h08};
			8'hAC, 8'hAD: res = {1'b1, 8'h00};
			// Variables, arrays, strings and load end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: res = {1'b1, end_a[7:0]};
			8'h2E, 8'h30, 8'h32, 8'hAF: res = {1'b1, end_a[15:8]};
			default: res = 9'h000;
		endcase
		return res;
	endfunction

	assign zp_patch = patch_byte(zp_addr[7:0], end_addr);
	assign beat_ok = dl_active_i && dl_beat_i.wr &&
		(state == load_pkg::LS_IDLE || state == load_pkg::LS_LOAD);

	// Host stalls until the queued byte has its slot
	assign dl_wait_o = wr_req_o.ce;
	assign autostart_o = (state == load_pkg::LS_DONE);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state <= load_pkg::LS_IDLE;
			wr_req_o <= '0;
			tape_load_o.load <= 1'b0;
			zp_addr <= '0;
		end else begin
			tape_load_o.load <= 1'b0;
			if (wr_grant_i) begin
				wr_req_o.ce <= 1'b0;
				wr_req_o.we <= 1'b0;
			end

			// ========================================
			// Download sequencing
			// ========================================
			case (state)
				load_pkg::LS_IDLE: begin
					if (dl_active_i && (dl_kind_i == load_pkg::KIND_PRG ||
						dl_kind_i == load_pkg::KIND_TAP)) begin
						state <= load_pkg::LS_LOAD;
						kind_q <= dl_kind_i;
						last_off <= '0;
					end
				end
				load_pkg::LS_LOAD: begin
					// End of download once the last byte is written
					if (!dl_active_i && !wr_req_o.ce) begin
						if (kind_q == load_pkg::KIND_PRG) begin
							state <= load_pkg::LS_PATCH;
							zp_addr <= '0;
						end else begin
							// One extra byte for the cassette model's early empty check
							tape_load_o.load <= 1'b1;
							tape_load_o.last <= TAP_BASE + last_off + ADDR_W'(2);
							state <= load_pkg::LS_IDLE;
						end
					end
				end
				load_pkg::LS_PATCH: begin
					if (!wr_req_o.ce) begin
						if (zp_addr == ZP_END) begin
							state <= load_pkg::LS_DONE;
						end else begin
							zp_addr <= zp_addr + 1'b1;
							if (zp_patch[8]) begin
								wr_req_o.ce <= 1'b1;
								wr_req_o.we <= 1'b1;
								wr_req_o.addr <= ADDR_W'(zp_addr);
								wr_req_o.data <= zp_patch[7:0];
							end
						end
					end
				end
				default: state <= load_pkg::LS_IDLE;
			endcase

			// ========================================
			// Beat handling
			// ========================================
			if (beat_ok && dl_kind_i == load_pkg::KIND_PRG) begin
				// Two header bytes give the load address
				if (dl_beat_i.offset == '0) begin
					prg_addr[7:0] <= dl_beat_i.data;
					end_addr[7:0] <= dl_beat_i.data;
				end else if (dl_beat_i.offset == ADDR_W'(1)) begin
					prg_addr[15:8] <= dl_beat_i.data;
					end_addr[15:8] <= dl_beat_i.data;
				end else begin
					wr_req_o.ce <= 1'b1;
					wr_req_o.we <= 1'b1;
					wr_req_o.addr <= ADDR_W'(prg_addr);
					wr_req_o.data <= dl_beat_i.data;
					prg_addr <= prg_addr + 1'b1;
					end_addr <= end_addr + 1'b1;
				end
			end else if (beat_ok && dl_kind_i == load_pkg::KIND_TAP) begin
				wr_req_o.ce <= 1'b1;
				wr_req_o.we <= 1'b1;
				wr_req_o.addr <= TAP_BASE + dl_beat_i.offset;
				wr_req_o.data <= dl_beat_i.data;
				last_off <= dl_beat_i.offset;
			end
		end
	end

	// Host keeps its strobe off while the loader stalls it
	a_no_beat_on_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		dl_wait_o |-> !dl_beat_i.wr);

endmodule

/* logic/tape_fetcher.sv */
// ========================================
// Reads the stored tape image back one byte at a time
// Play is toggled by the button and started by a new tape
// ========================================
`timescale 1ns/1ps
`include "loader_params.svh"

module tape_fetcher (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  load_pkg::tape_load_t tape_load_i,
	input  logic                 play_btn_i,
	output mem_pkg::mem_req_t    rd_req_o,
	input  logic                 rd_grant_i,
	input  logic [7:0]           rd_data_i,
	input  logic                 rd_valid_i,
	input  logic                 tape_ready_i,
	output logic [7:0]           tape_byte_o,
	output logic                 tape_valid_o,
	output logic                 tape_done_o
);
	localparam int ADDR_W = `LDR_ADDR_W;
	localparam logic [ADDR_W-1:0] TAP_BASE = `LDR_TAP_BASE;

	logic [ADDR_W-1:0] play_addr;
	logic [ADDR_W-1:0] last_addr;
	logic              playing;
	logic              have_tape;
	logic              btn_q;
	logic              rd_inflight;
	logic              loaded;

	assign loaded = (play_addr < last_addr);
	// Done only after the final byte came back from memory
	assign tape_done_o = have_tape && !loaded && !rd_inflight;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			play_addr <= TAP_BASE;
			last_addr <= '0;
			playing <= 1'b0;
			have_tape <= 1'b0;
			btn_q <= 1'b0;
			rd_inflight <= 1'b0;
			rd_req_o <= '0;
			tape_valid_o <= 1'b0;
		end else begin
			btn_q <= play_btn_i;
			tape_valid_o <= rd_valid_i;
			if (rd_valid_i)
				rd_inflight <= 1'b0;
			if (rd_grant_i) begin
				rd_req_o.ce <= 1'b0;
				play_addr <= play_addr + 1'b1;
				rd_inflight <= 1'b1;
			end

			// A fresh tape rewinds and starts playing
			if (tape_load_i.load) begin
				play_addr <= TAP_BASE;
				last_addr <= tape_load_i.last;
				have_tape <= 1'b1;
				playing <= 1'b1;
			end else if (play_btn_i && !btn_q) begin
				playing <= !playing;
			end else if (playing && tape_done_o) begin
				playing <= 1'b0;
			end

			// One read at a time, held back by the downstream ready
			if (playing && loaded && tape_ready_i && !rd_req_o.ce && !rd_inflight) begin
				rd_req_o.ce <= 1'b1;
				rd_req_o.we <= 1'b0;
				rd_req_o.addr <= play_addr;
				rd_req_o.data <= 8'h00;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_valid_i)
			tape_byte_o <= rd_data_i;
	end

	a_one_read: assert property (@(posedge clk_sys) disable iff (!reset_n)
		rd_inflight |-> !rd_req_o.ce);

endmodule

/* logic/mem_slot_arbiter.sv */
// ========================================
// Hands free memory slots to the loader or the tape fetcher
// Writes win over reads and read data is flagged after the fixed latency
// ========================================
`timescale 1ns/1ps
`include "loader_params.svh"

module mem_slot_arbiter (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              mem_slot_i,
	input  mem_pkg::mem_req_t wr_req_i,
	input  mem_pkg::mem_req_t rd_req_i,
	output logic              wr_grant_o,
	output logic              rd_grant_o,
	output mem_pkg::mem_req_t mem_req_o,
	input  logic [7:0]        mem_rdata_i,
	output logic [7:0]        rd_data_o,
	output logic              rd_valid_o
);
	localparam int RD_LAT = `LDR_RD_LAT;

	mem_pkg::slot_owner_e owner_next;
	mem_pkg::slot_owner_e owner_q;
	// Tape reads in flight with one stage per cycle of latency
	logic [RD_LAT:1]      rd_pipe;

	always_comb begin
		owner_next = mem_pkg::OWN_NONE;
		if (mem_slot_i) begin
			if (wr_req_i.ce)
				owner_next = mem_pkg::OWN_LOADER;
			else if (rd_req_i.ce)
				owner_next = mem_pkg::OWN_TAPE;
		end
	end

	assign wr_grant_o = (owner_next == mem_pkg::OWN_LOADER);
	assign rd_grant_o = (owner_next == mem_pkg::OWN_TAPE);
	assign rd_data_o = mem_rdata_i;
	assign rd_valid_o = rd_pipe[RD_LAT];

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			owner_q <= mem_pkg::OWN_NONE;
			mem_req_o <= '0;
			rd_pipe <= '0;
		end else begin
			owner_q <= owner_next;
			// owner_q marks the cycle the request sits on the port
			rd_pipe[1] <= (owner_q == mem_pkg::OWN_TAPE);
			for (int i = 2; i <= RD_LAT; i++)
				rd_pipe[i] <= rd_pipe[i-1];
			case (owner_next)
				mem_pkg::OWN_LOADER: mem_req_o <= wr_req_i;
				mem_pkg::OWN_TAPE: mem_req_o <= rd_req_i;
				default: begin
					mem_req_o.ce <= 1'b0;
					mem_req_o.we <= 1'b0;
				end
			endcase
		end
	end

	a_grant_onehot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(wr_grant_o && rd_grant_o));

endmodule

/* logic/loader_top.sv */
// ========================================
// Memory loader top level, loader and tape fetcher on one port
// ========================================
`timescale 1ns/1ps

module loader_top (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 dl_active_i,
	input  load_pkg::file_kind_e dl_kind_i,
	input  load_pkg::dl_beat_t   dl_beat_i,
	output logic                 dl_wait_o,
	output logic                 autostart_o,
	input  logic                 play_btn_i,
	input  logic                 tape_ready_i,
	output logic [7:0]           tape_byte_o,
	output logic                 tape_valid_o,
	output logic                 tape_done_o,
	input  logic                 mem_slot_i,
	output mem_pkg::mem_req_t    mem_req_o,
	input  logic [7:0]           mem_rdata_i
);
	mem_pkg::mem_req_t    wr_req;
	mem_pkg::mem_req_t    rd_req;
	logic                 wr_grant;
	logic                 rd_grant;
	logic [7:0]           rd_data;
	logic                 rd_valid;
	load_pkg::tape_load_t tape_load;

	image_loader u_loader (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_kind_i   (dl_kind_i),
		.dl_beat_i   (dl_beat_i),
		.dl_wait_o   (dl_wait_o),
		.wr_req_o    (wr_req),
		.wr_grant_i  (wr_grant),
		.tape_load_o (tape_load),
		.autostart_o (autostart_o)
	);

	tape_fetcher u_fetcher (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.tape_load_i  (tape_load),
		.play_btn_i   (play_btn_i),
		.rd_req_o     (rd_req),
		.rd_grant_i   (rd_grant),
		.rd_data_i    (rd_data),
		.rd_valid_i   (rd_valid),
		.tape_ready_i (tape_ready_i),
		.tape_byte_o  (tape_byte_o),
		.tape_valid_o (tape_valid_o),
		.tape_done_o  (tape_done_o)
	);

	mem_slot_arbiter u_arbiter (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.mem_slot_i  (mem_slot_i),
		.wr_req_i    (wr_req),
		.rd_req_i    (rd_req),
		.wr_grant_o  (wr_grant),
		.rd_grant_o  (rd_grant),
		.mem_req_o   (mem_req_o),
		.mem_rdata_i (mem_rdata_i),
		.rd_data_o   (rd_data),
		.rd_valid_o  (rd_valid)
	);

endmodule

/* testbench/tb_mem_model.sv */
// ========================================
// Behavioral memory for the loader testbench, fixed read latency
// Unwritten bytes read back a pattern of their address
// ========================================
`timescale 1ns/1ps
`include "loader_params.svh"

module tb_mem_model (
	input  logic              clk_sys,
	input  mem_pkg::mem_req_t mem_req_i,
	output logic [7:0]        mem_rdata_o
);
	localparam int LAT = `LDR_RD_LAT;

	logic [7:0] mem [logic [`LDR_ADDR_W-1:0]];
	logic [7:0] rd_pipe [1:LAT] = '{default: 8'h00};

	// Every address bit takes part in the pattern
	function automatic logic [7:0] fill_byte(input logic [`LDR_ADDR_W-1:0] a);
		return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ 8'h5a;
	endfunction

	// Backdoor read for checks
	function automatic logic [7:0] peek(input logic [`LDR_ADDR_W-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return fill_byte(a);
	endfunction

	assign mem_rdata_o = rd_pipe[LAT];

	always @(posedge clk_sys) begin
		if (mem_req_i.ce && mem_req_i.we)
			mem[mem_req_i.addr] = mem_req_i.data;
		rd_pipe[1] <= (mem_req_i.ce && !mem_req_i.we) ? peek(mem_req_i.addr) : 8'h00;
		for (int i = 2; i <= LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

endmodule

/* testbench/tb_loader.sv */
// ========================================
// Testbench for the memory loader, transfers applied from a table
// Checks memory contents, the BASIC pointer patch and tape playback
// ========================================
`timescale 1ns/1ps
`include "loader_params.svh"

module tb_loader;
	localparam int TMO = 4000;
	localparam logic [23:0] TAP_BASE = `LDR_TAP_BASE;

	// Playback mode 0 plain, 1 random ready, 2 paused by the button
	typedef struct {
		load_pkg::file_kind_e kind;
		logic [15:0]          addr;
		int                   len;
		logic [7:0]           seed;
		int                   mode;
	} xfer_t;

	logic                 clk_sys;
	logic                 reset_n;
	logic                 dl_active_i;
	load_pkg::file_kind_e dl_kind_i;
	load_pkg::dl_beat_t   dl_beat_i;
	logic                 dl_wait_o;
	logic                 autostart_o;
	logic                 play_btn_i;
	logic                 tape_ready_i;
	logic [7:0]           tape_byte_o;
	logic                 tape_valid_o;
	logic                 tape_done_o;
	logic                 mem_slot_i;
	mem_pkg::mem_req_t    mem_req_o;
	logic [7:0]           mem_rdata_i;

	xfer_t       xfers [5];
	logic [7:0]  exp_q [$];
	logic [7:0]  rx_q [$];
	logic [31:0] data_lfsr;
	logic [31:0] slot_lfsr;
	int          auto_cnt;
	int          val_errs;
	int          other_errs;

	loader_top u_dut (.*);

	tb_mem_model u_mem (
		.clk_sys     (clk_sys),
		.mem_req_i   (mem_req_o),
		.mem_rdata_o (mem_rdata_i)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================
	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Takes n bits, one step per bit
	task automatic draw(inout logic [31:0] st, input int n, output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], st[0]};
			st = lfsr_step(st);
		end
	endtask

	// Pointer values a LOAD leaves in the zero page, others keep the fill
	function automatic logic [7:0] zp_expect(input logic [7:0] a, input logic [15:0] end_a);
		case (a)
			8'h2B: return 8'h01;
			8'h2C: return 8'h08;
			8'hAC, 8'hAD: return 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: return end_a[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: return end_a[15:8];
			default: return u_mem.fill_byte(24'(a));
		endcase
	endfunction

	task automatic report_err(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
		val_errs++;
	endtask

	task automatic finish_run;
		$display("Errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic timed_out(input string what);
		$display("%0t timeout while waiting for %s", $time, what);
		other_errs++;
		finish_run();
	endtask

	task automatic press_button;
		@(posedge clk_sys);
		play_btn_i <= 1'b1;
		@(posedge clk_sys);
		play_btn_i <= 1'b0;
	endtask

	// ========================================
	// Download and checks
	// ========================================
	task automatic send_beat(input logic [23:0] off, input logic [7:0] d);
		int n;
		@(posedge clk_sys);
		dl_beat_i.wr <= 1'b1;
		dl_beat_i.offset <= off;
		dl_beat_i.data <= d;
		@(posedge clk_sys);
		dl_beat_i.wr <= 1'b0;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			if (n > TMO)
				timed_out("dl_wait_o to fall");
		end while (dl_wait_o);
	endtask

	task automatic download(input xfer_t x);
		logic [7:0] b;
		exp_q.delete();
		@(posedge clk_sys);
		dl_kind_i <= x.kind;
		dl_active_i <= 1'b1;
		if (x.kind == load_pkg::KIND_PRG) begin
			send_beat(24'd0, x.addr[7:0]);
			send_beat(24'd1, x.addr[15:8]);
		end
		for (int i = 0; i < x.len; i++) begin
			draw(data_lfsr, 8, b);
			b = b ^ x.seed;
			exp_q.push_back(b);
			send_beat((x.kind == load_pkg::KIND_PRG) ? 24'(i + 2) : 24'(i), b);
		end
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
	endtask

	task automatic check_prg(input xfer_t x, input int auto_base);
		int n;
		logic [15:0] a;
		logic [15:0] end_a;
		logic [7:0] got;
		n = 0;
		while (auto_cnt == auto_base) begin
			@(posedge clk_sys);
			n++;
			if (n > TMO)
				timed_out("autostart_o after the patch");
		end
		repeat (20) @(posedge clk_sys);
		if (auto_cnt != auto_base + 1)
			report_err("autostart_o pulses", auto_base + 1, auto_cnt);
		for (int i = 0; i < x.len; i++) begin
			a = x.addr + 16'(i);
			got = u_mem.peek(24'(a));
			if (got !== exp_q[i])
				report_err($sformatf("mem[%04h]", a), exp_q[i], got);
		end
		end_a = x.addr + 16'(x.len);
		for (int z = 0; z < `LDR_ZP_SIZE; z++) begin
			got = u_mem.peek(24'(z));
			if (got !== zp_expect(8'(z), end_a))
				report_err($sformatf("mem[%02h]", z), zp_expect(8'(z), end_a), got);
		end
	endtask

	task automatic play_tape(input xfer_t x, input int base);
		int n;
		int got_n;
		int held;
		logic paused;
		logic [7:0] r;
		logic [7:0] got;
		// The fetcher reads one byte past the image
		exp_q.push_back(u_mem.peek(TAP_BASE + 24'(x.len)));
		paused = 1'b0;
		n = 0;
		while (!(tape_done_o && rx_q.size() - base >= x.len + 1)) begin
			@(posedge clk_sys);
			if (x.mode == 1) begin
				draw(data_lfsr, 2, r);
				tape_ready_i <= (r != 8'h03);
			end
			if (x.mode == 2 && !paused && rx_q.size() - base >= 8) begin
				press_button();
				repeat (16) @(posedge clk_sys);
				held = rx_q.size();
				repeat (40) @(posedge clk_sys);
				if (rx_q.size() != held || held - base >= x.len + 1)
					begin
						$display("%0t tape stream did not stop on the button", $time);
						other_errs++;
					end
				press_button();
				paused = 1'b1;
			end
			n++;
			if (n > TMO)
				timed_out("tape playback to finish");
		end
		tape_ready_i <= 1'b1;
		repeat (10) @(posedge clk_sys);
		got_n = rx_q.size() - base;
		if (got_n != x.len + 1)
			report_err("tape_valid_o count", x.len + 1, got_n);
		for (int i = 0; i < x.len + 1 && i < got_n; i++) begin
			if (rx_q[base + i] !== exp_q[i])
				report_err($sformatf("tape_byte_o[%0d]", i), exp_q[i], rx_q[base + i]);
		end
		for (int i = 0; i < x.len; i++) begin
			got = u_mem.peek(TAP_BASE + 24'(i));
			if (got !== exp_q[i])
				report_err($sformatf("mem[%06h]", TAP_BASE + 24'(i)), exp_q[i], got);
		end
	endtask

	// ========================================
	// Processes
	// ========================================
	// Outputs are sampled on the falling edge
	initial begin
		auto_cnt = 0;
		forever begin
			@(negedge clk_sys);
			if (tape_valid_o)
				rx_q.push_back(tape_byte_o);
			if (autostart_o)
				auto_cnt++;
		end
	end

	// Free memory slots at random gaps of 2 to 5 cycles
	initial begin : slot_gen
		int gap;
		logic [7:0] g;
		mem_slot_i = 1'b0;
		slot_lfsr = 32'h5c4c;
		gap = 0;
		forever begin
			@(posedge clk_sys);
			if (gap == 0) begin
				mem_slot_i <= 1'b1;
				draw(slot_lfsr, 2, g);
				gap = int'(g) + 1;
			end else begin
				mem_slot_i <= 1'b0;
				gap--;
			end
		end
	end

	initial begin : main
		int base;
		int auto_base;
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_kind_i = load_pkg::KIND_PRG;
		dl_beat_i = '0;
		play_btn_i = 1'b0;
		tape_ready_i = 1'b1;
		data_lfsr = 32'h5c4c;
		val_errs = 0;
		other_errs = 0;
		xfers[0] = '{load_pkg::KIND_PRG, 16'h0801, 40, 8'h00, 0};
		xfers[1] = '{load_pkg::KIND_TAP, 16'h0000, 32, 8'h3c, 0};
		xfers[2] = '{load_pkg::KIND_PRG, 16'hc000, 24, 8'ha5, 0};
		xfers[3] = '{load_pkg::KIND_TAP, 16'h0000, 40, 8'h5a, 1};
		xfers[4] = '{load_pkg::KIND_TAP, 16'h0000, 48, 8'hc3, 2};

		repeat (2) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(posedge clk_sys);
		if ({dl_wait_o, tape_valid_o, autostart_o, mem_req_o.ce, mem_req_o.we, tape_done_o}
			!== 6'b0)
			report_err("{dl_wait_o,tape_valid_o,autostart_o,ce,we,tape_done_o}", 0,
				{dl_wait_o, tape_valid_o, autostart_o, mem_req_o.ce, mem_req_o.we,
				tape_done_o});

		for (int r = 0; r < 5; r++) begin
			base = rx_q.size();
			auto_base = auto_cnt;
			download(xfers[r]);
			if (xfers[r].kind == load_pkg::KIND_PRG)
				check_prg(xfers[r], auto_base);
			else
				play_tape(xfers[r], base);
		end
		finish_run();
	end

endmodule

/* verilog.f */
+incdir+logic
logic/mem_pkg.sv
logic/load_pkg.sv
logic/image_loader.sv
logic/tape_fetcher.sv
logic/mem_slot_arbiter.sv
logic/loader_top.sv
testbench/tb_mem_model.sv
testbench/tb_loader.sv

/* Makefile */
# Verilator build and run of the memory loader testbench
VERILATOR ?= verilator
TOP       ?= tb_loader
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
